// ==== all.f ====
vmul_op_pkg.sv
vmul_ctl_pkg.sv
vmul_issue_seq.sv
vmul_mul_array.sv
vmul_collect.sv
vmul_unit.sv
tb_vmul_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vmul_unit testbench with Verilator
# exit status is 0 only when the run log holds no failure

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_vmul_unit

verilator --binary --timing --assert \
  -f all.f \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi

echo "no failure found in $LOG"
exit 0

// ==== tb_vmul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vmul_unit
  import vmul_op_pkg::*;
();

  localparam int WIDTH         = 16;
  localparam int NUM_LANES     = 8;
  localparam int NUM_MUL_LANES = 2;
  localparam int REGID_W       = 4;
  localparam int SHAMT_W       = $clog2(WIDTH);
  localparam int P             = NUM_LANES / NUM_MUL_LANES;
  localparam int V_W           = NUM_LANES * WIDTH;
  localparam int NUM_ROWS      = 16;
  localparam int DRAIN_LIMIT   = 10 * (P + 2);

  // hand-checked vectors, element 0 is the last entry of each concatenation
  localparam logic [V_W-1:0] FIX_A =
    {16'h0000, 16'hFFFE, 16'h1234, 16'h8000, 16'h7FFF, 16'h0100, 16'hFFFF, 16'h0003};
  localparam logic [V_W-1:0] FIX_B =
    {16'h5A5A, 16'hFFFD, 16'h0010, 16'h0002, 16'h0002, 16'h0100, 16'h0003, 16'h0005};
  localparam logic [V_W-1:0] EXP_LO =
    {16'h0000, 16'h0006, 16'h2340, 16'h0000, 16'hFFFE, 16'h0000, 16'hFFFD, 16'h000F};
  localparam logic [V_W-1:0] EXP_HI =
    {16'h0000, 16'h0000, 16'h0001, 16'hFFFF, 16'h0000, 16'h0001, 16'hFFFF, 16'h0000};
  localparam logic [V_W-1:0] EXP_HIU =
    {16'h0000, 16'hFFFB, 16'h0001, 16'h0001, 16'h0000, 16'h0001, 16'h0002, 16'h0000};
  // signed product shifted down by 4
  localparam logic [V_W-1:0] EXP_FX4 =
    {16'h0000, 16'h0000, 16'h1234, 16'hF000, 16'h0FFF, 16'h1000, 16'hFFFF, 16'h0000};
  // shift amounts 0, 15, 4, 0, 15, 1, 8, 3 from the low nibble of b
  localparam logic [V_W-1:0] SLL_A =
    {16'h7FFF, 16'h00F0, 16'h8001, 16'hFFFF, 16'h1234, 16'hABCD, 16'h0001, 16'h0001};
  localparam logic [V_W-1:0] SLL_B =
    {16'h0003, 16'hFFF8, 16'h0001, 16'h001F, 16'h0010, 16'h0004, 16'h000F, 16'h0000};
  localparam logic [V_W-1:0] EXP_SLL =
    {16'hFFF8, 16'hF000, 16'h0002, 16'h8000, 16'h1234, 16'hBCD0, 16'h8000, 16'h0001};
  // q15 style operands, shift by 15
  localparam logic [V_W-1:0] FX_A =
    {16'h8000, 16'h2000, 16'hFFFF, 16'h0001, 16'h8000, 16'h7FFF, 16'hC000, 16'h4000};
  localparam logic [V_W-1:0] FX_B =
    {16'h7FFF, 16'hE000, 16'h0001, 16'h0001, 16'h8000, 16'h7FFF, 16'h4000, 16'h4000};
  localparam logic [V_W-1:0] EXP_FX15 =
    {16'h8001, 16'hF800, 16'hFFFF, 16'h0000, 16'h8000, 16'h7FFE, 16'hE000, 16'h2000};

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  logic [2:0]           op;
  logic [SHAMT_W-1:0]   vshamt;
  logic [V_W-1:0]       opa;
  logic [V_W-1:0]       opb;
  logic [NUM_LANES-1:0] vmask;
  logic [REGID_W-1:0]   dst;
  logic                 dst_we;
  logic                 busy;
  logic                 out_valid;
  logic [V_W-1:0]       result;
  logic [REGID_W-1:0]   out_dst;
  logic                 out_dst_we;
  logic [NUM_LANES-1:0] out_mask;

  // stimulus table
  logic [2:0]           t_op   [NUM_ROWS];
  logic [SHAMT_W-1:0]   t_sh   [NUM_ROWS];
  logic [NUM_LANES-1:0] t_mask [NUM_ROWS];
  logic [REGID_W-1:0]   t_dst  [NUM_ROWS];
  logic                 t_we   [NUM_ROWS];
  logic                 t_rnd  [NUM_ROWS];
  int                   t_gap  [NUM_ROWS];
  logic [V_W-1:0]       t_a    [NUM_ROWS];
  logic [V_W-1:0]       t_b    [NUM_ROWS];
  logic [V_W-1:0]       t_exp  [NUM_ROWS];

  // expected results in issue order
  logic [V_W-1:0]       exp_res_q  [$];
  logic [REGID_W-1:0]   exp_dst_q  [$];
  logic                 exp_we_q   [$];
  logic [NUM_LANES-1:0] exp_mask_q [$];
  // cycles at which out_valid is due
  int                   due_q      [$];

  int seed         = 75359;
  int cyc          = 0;
  int busy_from    = 1;
  int busy_to      = 0;
  int value_errs   = 0;
  int timing_errs  = 0;
  int timeout_errs = 0;

  vmul_unit #(
    .WIDTH         (WIDTH),
    .NUM_LANES     (NUM_LANES),
    .NUM_MUL_LANES (NUM_MUL_LANES),
    .REGID_W       (REGID_W)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .op         (op),
    .vshamt     (vshamt),
    .opa        (opa),
    .opb        (opb),
    .vmask      (vmask),
    .dst        (dst),
    .dst_we     (dst_we),
    .busy       (busy),
    .out_valid  (out_valid),
    .result     (result),
    .out_dst    (out_dst),
    .out_dst_we (out_dst_we),
    .out_mask   (out_mask)
  );

  always #10 clk = ~clk;

  // cycle n lies between rising edge n and n+1
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // one element from the operation rules
  function automatic logic [WIDTH-1:0] ref_elem(input logic [2:0] o,
                                                input logic [SHAMT_W-1:0] sh,
                                                input logic [WIDTH-1:0] a,
                                                input logic [WIDTH-1:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sp;
    logic signed [63:0] fx;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        up;
    logic [63:0]        sl;
    logic [WIDTH-1:0]   r;
    sa = {{(64-WIDTH){a[WIDTH-1]}}, a};
    sb = {{(64-WIDTH){b[WIDTH-1]}}, b};
    ua = {{(64-WIDTH){1'b0}}, a};
    ub = {{(64-WIDTH){1'b0}}, b};
    sp = sa * sb;
    up = ua * ub;
    fx = sp >>> sh;
    sl = ua << b[SHAMT_W-1:0];
    case (o)
      OP_MULLO:  r = sp[WIDTH-1:0];
      OP_MULHI:  r = sp[2*WIDTH-1:WIDTH];
      OP_MULHIU: r = up[2*WIDTH-1:WIDTH];
      OP_MULFX:  r = fx[WIDTH-1:0];
      OP_SLL:    r = sl[WIDTH-1:0];
      default:   r = 'x;
    endcase
    return r;
  endfunction

  function automatic logic [V_W-1:0] ref_vector(input logic [2:0] o,
                                                input logic [SHAMT_W-1:0] sh,
                                                input logic [V_W-1:0] a,
                                                input logic [V_W-1:0] b);
    logic [V_W-1:0] v;
    int             k;
    v = '0;
    for (k = 0; k < NUM_LANES; k++)
      v[k*WIDTH +: WIDTH] = ref_elem(o, sh, a[k*WIDTH +: WIDTH], b[k*WIDTH +: WIDTH]);
    return v;
  endfunction

  task rand_vec(output logic [V_W-1:0] v);
    logic [31:0] rnd;
    int          k;
    for (k = 0; k < NUM_LANES; k++)
    begin
      rnd = $random(seed);
      v[k*WIDTH +: WIDTH] = rnd[WIDTH-1:0];
    end
  endtask

  task set_row(input int i, input logic [2:0] o, input logic [SHAMT_W-1:0] sh,
               input logic [NUM_LANES-1:0] m, input logic [REGID_W-1:0] d,
               input logic w, input logic r, input int g,
               input logic [V_W-1:0] a, input logic [V_W-1:0] b,
               input logic [V_W-1:0] e);
    t_op[i]   = o;
    t_sh[i]   = sh;
    t_mask[i] = m;
    t_dst[i]  = d;
    t_we[i]   = w;
    t_rnd[i]  = r;
    t_gap[i]  = g;
    t_a[i]    = a;
    t_b[i]    = b;
    t_exp[i]  = e;
  endtask

  // gap 0 issues at the earliest cycle, otherwise drain and idle
  task fill_table();
    set_row(0,  OP_MULLO,  4'd0,  8'hFF, 4'h1, 1'b1, 1'b0, 0, FIX_A, FIX_B, EXP_LO);
    set_row(1,  OP_MULHI,  4'd0,  8'hA5, 4'h2, 1'b1, 1'b0, 0, FIX_A, FIX_B, EXP_HI);
    set_row(2,  OP_MULHIU, 4'd0,  8'h00, 4'h3, 1'b0, 1'b0, 0, FIX_A, FIX_B, EXP_HIU);
    set_row(3,  OP_MULFX,  4'd4,  8'h0F, 4'h4, 1'b1, 1'b0, 3, FIX_A, FIX_B, EXP_FX4);
    set_row(4,  OP_SLL,    4'd7,  8'hF0, 4'h5, 1'b1, 1'b0, 0, SLL_A, SLL_B, EXP_SLL);
    set_row(5,  OP_MULFX,  4'd15, 8'h81, 4'h6, 1'b1, 1'b0, 0, FX_A, FX_B, EXP_FX15);
    set_row(6,  OP_MULLO,  4'd0,  8'h3C, 4'h7, 1'b1, 1'b1, 2, '0, '0, '0);
    set_row(7,  OP_MULHI,  4'd0,  8'hFF, 4'h8, 1'b0, 1'b1, 0, '0, '0, '0);
    set_row(8,  OP_MULHIU, 4'd3,  8'h55, 4'h9, 1'b1, 1'b1, 0, '0, '0, '0);
    set_row(9,  OP_MULFX,  4'd0,  8'hAA, 4'hA, 1'b1, 1'b1, 0, '0, '0, '0);
    set_row(10, OP_MULFX,  4'd9,  8'h01, 4'hB, 1'b1, 1'b1, 5, '0, '0, '0);
    set_row(11, OP_SLL,    4'd0,  8'hFE, 4'hC, 1'b1, 1'b1, 0, '0, '0, '0);
    set_row(12, OP_MULFX,  4'd15, 8'h00, 4'hD, 1'b0, 1'b1, 0, '0, '0, '0);
    set_row(13, OP_MULHIU, 4'd0,  8'h7E, 4'hE, 1'b1, 1'b1, 1, '0, '0, '0);
    set_row(14, OP_SLL,    4'd2,  8'hFF, 4'hF, 1'b1, 1'b1, 0, '0, '0, '0);
    set_row(15, OP_MULLO,  4'd0,  8'h96, 4'h0, 1'b1, 1'b1, 0, '0, '0, '0);
  endtask

  // one strobe, then idle up to the earliest next issue cycle
  task automatic apply_row(input int i);
    logic [V_W-1:0] a_v;
    logic [V_W-1:0] b_v;
    logic [V_W-1:0] e_v;
    if (t_rnd[i])
    begin
      rand_vec(a_v);
      rand_vec(b_v);
      e_v = ref_vector(t_op[i], t_sh[i], a_v, b_v);
    end
    else
    begin
      a_v = t_a[i];
      b_v = t_b[i];
      e_v = t_exp[i];
    end
    exp_res_q.push_back(e_v);
    exp_dst_q.push_back(t_dst[i]);
    exp_we_q.push_back(t_we[i]);
    exp_mask_q.push_back(t_mask[i]);
    @(posedge clk);
    in_valid <= 1'b1;
    op       <= t_op[i];
    vshamt   <= t_sh[i];
    opa      <= a_v;
    opb      <= b_v;
    vmask    <= t_mask[i];
    dst      <= t_dst[i];
    dst_we   <= t_we[i];
    @(posedge clk);
    in_valid <= 1'b0;
    // junk on the operand lines, the parked copy must be used
    rand_vec(a_v);
    rand_vec(b_v);
    opa <= a_v;
    opb <= b_v;
    repeat (P - 1) @(posedge clk);
  endtask

  // wait for every outstanding result to come back
  task automatic wait_for_results(input int limit);
    int n;
    n = 0;
    while (exp_res_q.size() != 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_res_q.size() != 0)
    begin
      timeout_errs++;
      $display("timeout: %0d results still missing after %0d cycles", exp_res_q.size(), n);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk)
  begin : monitor
    logic           exp_busy;
    logic           exp_out;
    logic [V_W-1:0] exp_v;
    int             k;
    if (rst_n)
    begin
      exp_busy = (cyc >= busy_from) && (cyc <= busy_to);
      exp_out  = (due_q.size() > 0) && (due_q[0] == cyc);
      if (busy !== exp_busy)
      begin
        timing_errs++;
        $display("FAILED busy at cycle %0d: got %h expected %h", cyc, busy, exp_busy);
      end
      if (out_valid !== exp_out)
      begin
        timing_errs++;
        $display("FAILED out_valid at cycle %0d: got %h expected %h", cyc, out_valid, exp_out);
      end
      if (exp_out)
      begin
        void'(due_q.pop_front());
        exp_v = exp_res_q.pop_front();
        if (out_valid === 1'b1)
        begin
          for (k = 0; k < NUM_LANES; k++)
            if (result[k*WIDTH +: WIDTH] !== exp_v[k*WIDTH +: WIDTH])
            begin
              value_errs++;
              $display("FAILED result[%0d]: got %h expected %h", k,
                       result[k*WIDTH +: WIDTH], exp_v[k*WIDTH +: WIDTH]);
            end
          if (out_dst !== exp_dst_q[0])
          begin
            value_errs++;
            $display("FAILED out_dst: got %h expected %h", out_dst, exp_dst_q[0]);
          end
          if (out_dst_we !== exp_we_q[0])
          begin
            value_errs++;
            $display("FAILED out_dst_we: got %h expected %h", out_dst_we, exp_we_q[0]);
          end
          if (out_mask !== exp_mask_q[0])
          begin
            value_errs++;
            $display("FAILED out_mask: got %h expected %h", out_mask, exp_mask_q[0]);
          end
        end
        void'(exp_dst_q.pop_front());
        void'(exp_we_q.pop_front());
        void'(exp_mask_q.pop_front());
      end
      // a new request opens the busy window and books its result cycle
      if (in_valid === 1'b1)
      begin
        if (busy !== 1'b0)
        begin
          timing_errs++;
          $display("request was strobed at cycle %0d while the unit was busy", cyc);
        end
        busy_from = cyc + 1;
        busy_to   = cyc + P;
        due_q.push_back(cyc + P + 2);
      end
    end
  end

  initial
  begin
    int i;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    op       = OP_MULLO;
    vshamt   = '0;
    opa      = '0;
    opb      = '0;
    vmask    = '0;
    dst      = '0;
    dst_we   = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // quiet period, busy and out_valid have to stay low
    repeat (10) @(posedge clk);
    for (i = 0; i < NUM_ROWS && timeout_errs == 0; i++)
    begin
      if (t_gap[i] > 0)
      begin
        wait_for_results(DRAIN_LIMIT);
        repeat (t_gap[i]) @(posedge clk);
      end
      apply_row(i);
    end
    wait_for_results(DRAIN_LIMIT);
    // no stray strobe after the last result
    repeat (6) @(posedge clk);
    $display("errors: %0d value, %0d timing, %0d timeout", value_errs, timing_errs,
             timeout_errs);
    if (value_errs == 0 && timing_errs == 0 && timeout_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vmul_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmul_collect
  import vmul_ctl_pkg::*;
#(
  parameter int WIDTH         = 16,
  parameter int NUM_LANES     = 8,
  parameter int NUM_MUL_LANES = 2,
  parameter int REGID_W       = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // product groups from the array
  input  logic                           prod_valid,
  input  logic [1:0]                     prod_pos,
  input  logic [NUM_MUL_LANES*WIDTH-1:0] prod_data,
  // issue side that supplies the tag on the last group
  input  logic                           iss_valid,
  input  logic [1:0]                     iss_pos,
  input  logic [REGID_W-1:0]             seq_dst,
  input  logic                           seq_dst_we,
  input  logic [NUM_LANES-1:0]           seq_mask,
  // assembled result
  output logic                           out_valid,
  output logic [NUM_LANES*WIDTH-1:0]     result,
  output logic [REGID_W-1:0]             out_dst,
  output logic                           out_dst_we,
  output logic [NUM_LANES-1:0]           out_mask
);

  localparam int G_W = NUM_MUL_LANES * WIDTH;
  localparam int V_W = NUM_LANES * WIDTH;

  // partial vector where new groups enter at the top
  logic [V_W-1:0]       res_sh;
  logic [V_W+G_W-1:0]   cat;
  logic [V_W-1:0]       assembled;
  // tag copied when the sequencer issues its last group
  logic [REGID_W-1:0]   hold_dst;
  logic                 hold_dst_we;
  logic [NUM_LANES-1:0] hold_mask;
  logic                 iss_end;
  logic                 prod_end;
  // high while a multi-pass vector is being gathered
  logic                 collecting;

  assign iss_end  = iss_valid && (iss_pos == GRP_LAST || iss_pos == GRP_ONLY);
  assign prod_end = prod_valid && (prod_pos == GRP_LAST || prod_pos == GRP_ONLY);

  // the new group enters at the top and the oldest group falls toward element 0
  assign cat       = {prod_data, res_sh};
  assign assembled = cat[V_W+G_W-1:G_W];

  always_ff @(posedge clk)
  begin
    if (prod_valid)
      res_sh <= assembled;
    if (iss_end)
    begin
      hold_dst  <= seq_dst;
      hold_mask <= seq_mask;
    end
    // full vector and tag leave together
    if (prod_end)
    begin
      result   <= assembled;
      out_dst  <= hold_dst;
      out_mask <= hold_mask;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid   <= 1'b0;
      out_dst_we  <= 1'b0;
      hold_dst_we <= 1'b0;
      collecting  <= 1'b0;
    end
    else
    begin
      // one-cycle strobe with no back-pressure
      out_valid <= prod_end;
      if (iss_end)
        hold_dst_we <= seq_dst_we;
      if (prod_end)
        out_dst_we <= hold_dst_we;
      if (prod_valid && prod_pos == GRP_FIRST)
        collecting <= 1'b1;
      else if (prod_end)
        collecting <= 1'b0;
    end
  end

  // middle and last groups only ever follow a first group
  a_no_orphan_group: assert property (
    @(posedge clk) disable iff (!rst_n)
      (prod_valid && (prod_pos == GRP_MID || prod_pos == GRP_LAST)) |-> collecting
  );

endmodule

`default_nettype wire

// ==== vmul_ctl_pkg.sv ====
`default_nettype none

package vmul_ctl_pkg;

  // position of an element group within its vector
  // travels with every issued group and every product group
  typedef enum logic [1:0] {
    // neither first nor last pass
    GRP_MID   = 2'd0,
    // first pass of a multi-pass vector
    GRP_FIRST = 2'd1,
    // last pass, closes the vector
    GRP_LAST  = 2'd2,
    // whole vector fits in one pass
    GRP_ONLY  = 2'd3
  } grp_pos_e;

endpackage

`default_nettype wire

// ==== vmul_issue_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmul_issue_seq
  import vmul_op_pkg::*;
  import vmul_ctl_pkg::*;
#(
  parameter int WIDTH         = 16,
  parameter int NUM_LANES     = 8,
  parameter int NUM_MUL_LANES = 2,
  parameter int REGID_W       = 4,
  localparam int SHAMT_W      = $clog2(WIDTH)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // request side
  input  logic                           in_valid,
  input  logic [VMUL_OP_W-1:0]           op,
  input  logic [SHAMT_W-1:0]             vshamt,
  input  logic [NUM_LANES*WIDTH-1:0]     opa,
  input  logic [NUM_LANES*WIDTH-1:0]     opb,
  input  logic [NUM_LANES-1:0]           vmask,
  input  logic [REGID_W-1:0]             dst,
  input  logic                           dst_we,
  output logic                           busy,
  // one element group per cycle towards the array
  output logic                           iss_valid,
  output logic [1:0]                     iss_pos,
  output logic [VMUL_OP_W-1:0]           iss_op,
  output logic [SHAMT_W-1:0]             iss_shamt,
  output logic [NUM_MUL_LANES*WIDTH-1:0] iss_a,
  output logic [NUM_MUL_LANES*WIDTH-1:0] iss_b,
  // tag of the request being issued, read by the collector
  output logic [REGID_W-1:0]             seq_dst,
  output logic                           seq_dst_we,
  output logic [NUM_LANES-1:0]           seq_mask
);

  // number of passes over the multipliers
  localparam int P     = NUM_LANES / NUM_MUL_LANES;
  // bits in one element group
  localparam int G_W   = NUM_MUL_LANES * WIDTH;
  localparam int CNT_W = (P > 1) ? $clog2(P) : 1;
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(P - 1);

  logic                       active;
  logic [CNT_W-1:0]           pass_cnt;
  // parked operands, group 0 always sits in the low bits
  logic [NUM_LANES*WIDTH-1:0] a_sh;
  logic [NUM_LANES*WIDTH-1:0] b_sh;
  vmul_op_e                   op_q;
  logic [SHAMT_W-1:0]         shamt_q;
  logic                       first_pass;
  logic                       last_pass;
  grp_pos_e                   pos;

  // pass counter runs for P cycles after an accepted request
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      active     <= 1'b0;
      pass_cnt   <= '0;
      seq_dst_we <= 1'b0;
    end
    else if (in_valid)
    begin
      active     <= 1'b1;
      pass_cnt   <= '0;
      seq_dst_we <= dst_we;
    end
    else if (active)
    begin
      pass_cnt <= pass_cnt + 1'b1;
      // drop busy after the last group has gone out
      if (pass_cnt == LAST_CNT)
        active <= 1'b0;
    end
  end

  // operand and tag registers
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      a_sh     <= opa;
      b_sh     <= opb;
      op_q     <= vmul_op_e'(op);
      shamt_q  <= vshamt;
      seq_dst  <= dst;
      seq_mask <= vmask;
    end
    else if (active)
    begin
      // move the next group down into the issue slot
      a_sh <= a_sh >> G_W;
      b_sh <= b_sh >> G_W;
    end
  end

  assign first_pass = (pass_cnt == '0);
  assign last_pass  = (pass_cnt == LAST_CNT);

  // mark where this group sits in the vector
  always_comb
  begin
    case ({first_pass, last_pass})
      2'b11:   pos = GRP_ONLY;
      2'b10:   pos = GRP_FIRST;
      2'b01:   pos = GRP_LAST;
      default: pos = GRP_MID;
    endcase
  end

  assign busy      = active;
  assign iss_valid = active;
  assign iss_pos   = pos;
  assign iss_op    = op_q;
  assign iss_shamt = shamt_q;
  assign iss_a     = a_sh[G_W-1:0];
  assign iss_b     = b_sh[G_W-1:0];

  // the issuer has to wait until the passes of the previous request are out
  a_no_issue_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) in_valid |-> !busy
  );

  // only the five defined operations may be requested
  a_legal_op: assert property (
    @(posedge clk) disable iff (!rst_n) in_valid |-> op_legal(op)
  );

endmodule

`default_nettype wire

// ==== vmul_mul_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmul_mul_array
  import vmul_op_pkg::*;
  import vmul_ctl_pkg::*;
#(
  parameter int WIDTH         = 16,
  parameter int NUM_MUL_LANES = 2,
  localparam int SHAMT_W      = $clog2(WIDTH)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           iss_valid,
  input  logic [1:0]                     iss_pos,
  input  logic [VMUL_OP_W-1:0]           iss_op,
  input  logic [SHAMT_W-1:0]             iss_shamt,
  input  logic [NUM_MUL_LANES*WIDTH-1:0] iss_a,
  input  logic [NUM_MUL_LANES*WIDTH-1:0] iss_b,
  output logic                           prod_valid,
  output logic [1:0]                     prod_pos,
  output logic [NUM_MUL_LANES*WIDTH-1:0] prod_data
);

  vmul_op_e op;
  // every operation is signed except the unsigned high product
  logic     sgn;
  // set between a first and a last product group
  logic     grp_open;

  assign op  = vmul_op_e'(iss_op);
  assign sgn = (op != OP_MULHIU);

  genvar k;
  generate
    for (k = 0; k < NUM_MUL_LANES; k++)
    begin : g_slice
      logic [WIDTH-1:0]            a;
      logic [WIDTH-1:0]            b;
      logic [WIDTH-1:0]            b_pow2;
      // one extra bit turns both signed and unsigned into a signed multiply
      logic signed [WIDTH:0]       a_x;
      logic signed [WIDTH:0]       b_x;
      logic signed [2*WIDTH+1:0]   prod_x;
      logic [2*WIDTH-1:0]          full;
      logic signed [2*WIDTH-1:0]   fx;
      logic [WIDTH-1:0]            sel;
      logic [WIDTH-1:0]            res_q;

      assign a = iss_a[k*WIDTH +: WIDTH];
      assign b = iss_b[k*WIDTH +: WIDTH];

      // shift left as a multiply by a power of two
      assign b_pow2 = WIDTH'(1) << b[SHAMT_W-1:0];

      assign a_x = {sgn & a[WIDTH-1], a};
      // the power of two is always positive, so it is zero extended
      assign b_x = (op == OP_SLL) ? {1'b0, b_pow2} : {sgn & b[WIDTH-1], b};

      assign prod_x = (2*WIDTH+2)'(a_x) * (2*WIDTH+2)'(b_x);
      assign full   = prod_x[2*WIDTH-1:0];

      // fixed point takes the whole product shifted down with its sign kept
      assign fx = $signed(full) >>> iss_shamt;

      always_comb
      begin
        case (op)
          OP_MULHI,
          OP_MULHIU: sel = full[2*WIDTH-1:WIDTH];
          OP_MULFX:  sel = fx[WIDTH-1:0];
          default:   sel = full[WIDTH-1:0];
        endcase
      end

      // single register stage per slice
      always_ff @(posedge clk)
      begin
        res_q <= sel;
      end

      assign prod_data[k*WIDTH +: WIDTH] = res_q;
    end
  endgenerate

  // valid and position follow the data by one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      prod_valid <= 1'b0;
      prod_pos   <= GRP_MID;
    end
    else
    begin
      prod_valid <= iss_valid;
      prod_pos   <= iss_pos;
    end
  end

  // tracks an open multi-pass vector on the product side
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      grp_open <= 1'b0;
    else if (prod_valid)
    begin
      if (prod_pos == GRP_FIRST)
        grp_open <= 1'b1;
      else if (prod_pos == GRP_LAST || prod_pos == GRP_ONLY)
        grp_open <= 1'b0;
    end
  end

  // a new vector cannot start before the previous one has been closed
  a_no_double_first: assert property (
    @(posedge clk) disable iff (!rst_n)
      (prod_valid && prod_pos == GRP_FIRST) |-> !grp_open
  );

endmodule

`default_nettype wire

// ==== vmul_op_pkg.sv ====
`default_nettype none

package vmul_op_pkg;

  // width of the operation field carried with a request
  localparam int VMUL_OP_W = 3;

  // operation codes understood by the multiplier array
  // codes 5 to 7 are illegal
  typedef enum logic [VMUL_OP_W-1:0] {
    // low half of the signed product
    OP_MULLO  = 3'd0,
    // high half of the signed product
    OP_MULHI  = 3'd1,
    // high half of the unsigned product
    OP_MULHIU = 3'd2,
    // signed product shifted right arithmetically by vshamt
    OP_MULFX  = 3'd3,
    // opa shifted left by the low bits of opb, done on the multiplier
    OP_SLL    = 3'd4
  } vmul_op_e;

  // true for the five defined codes
  function automatic logic op_legal(input logic [VMUL_OP_W-1:0] code);
    return code inside {OP_MULLO, OP_MULHI, OP_MULHIU, OP_MULFX, OP_SLL};
  endfunction

endpackage

`default_nettype wire

// ==== vmul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vmul_unit #(
  parameter int WIDTH         = 16,
  parameter int NUM_LANES     = 8,
  parameter int NUM_MUL_LANES = 2,
  parameter int REGID_W       = 4,
  localparam int SHAMT_W      = $clog2(WIDTH)
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // request strobe, only while busy is low
  input  logic                       in_valid,
  // operation code, same encoding as vmul_op_e
  input  logic [2:0]                 op,
  input  logic [SHAMT_W-1:0]         vshamt,
  input  logic [NUM_LANES*WIDTH-1:0] opa,
  input  logic [NUM_LANES*WIDTH-1:0] opb,
  input  logic [NUM_LANES-1:0]       vmask,
  input  logic [REGID_W-1:0]         dst,
  input  logic                       dst_we,
  output logic                       busy,
  // result strobe, P+2 cycles after in_valid
  output logic                       out_valid,
  output logic [NUM_LANES*WIDTH-1:0] result,
  output logic [REGID_W-1:0]         out_dst,
  output logic                       out_dst_we,
  output logic [NUM_LANES-1:0]       out_mask
);

  // sequencer to array
  logic                           iss_valid;
  logic [1:0]                     iss_pos;
  logic [2:0]                     iss_op;
  logic [SHAMT_W-1:0]             iss_shamt;
  logic [NUM_MUL_LANES*WIDTH-1:0] iss_a;
  logic [NUM_MUL_LANES*WIDTH-1:0] iss_b;
  // held tag, sequencer to collector
  logic [REGID_W-1:0]             seq_dst;
  logic                           seq_dst_we;
  logic [NUM_LANES-1:0]           seq_mask;
  // array to collector
  logic                           prod_valid;
  logic [1:0]                     prod_pos;
  logic [NUM_MUL_LANES*WIDTH-1:0] prod_data;

  vmul_issue_seq #(
    .WIDTH         (WIDTH),
    .NUM_LANES     (NUM_LANES),
    .NUM_MUL_LANES (NUM_MUL_LANES),
    .REGID_W       (REGID_W)
  ) u_issue_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .op         (op),
    .vshamt     (vshamt),
    .opa        (opa),
    .opb        (opb),
    .vmask      (vmask),
    .dst        (dst),
    .dst_we     (dst_we),
    .busy       (busy),
    .iss_valid  (iss_valid),
    .iss_pos    (iss_pos),
    .iss_op     (iss_op),
    .iss_shamt  (iss_shamt),
    .iss_a      (iss_a),
    .iss_b      (iss_b),
    .seq_dst    (seq_dst),
    .seq_dst_we (seq_dst_we),
    .seq_mask   (seq_mask)
  );

  vmul_mul_array #(
    .WIDTH         (WIDTH),
    .NUM_MUL_LANES (NUM_MUL_LANES)
  ) u_mul_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .iss_valid  (iss_valid),
    .iss_pos    (iss_pos),
    .iss_op     (iss_op),
    .iss_shamt  (iss_shamt),
    .iss_a      (iss_a),
    .iss_b      (iss_b),
    .prod_valid (prod_valid),
    .prod_pos   (prod_pos),
    .prod_data  (prod_data)
  );

  vmul_collect #(
    .WIDTH         (WIDTH),
    .NUM_LANES     (NUM_LANES),
    .NUM_MUL_LANES (NUM_MUL_LANES),
    .REGID_W       (REGID_W)
  ) u_collect (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_valid (prod_valid),
    .prod_pos   (prod_pos),
    .prod_data  (prod_data),
    .iss_valid  (iss_valid),
    .iss_pos    (iss_pos),
    .seq_dst    (seq_dst),
    .seq_dst_we (seq_dst_we),
    .seq_mask   (seq_mask),
    .out_valid  (out_valid),
    .result     (result),
    .out_dst    (out_dst),
    .out_dst_we (out_dst_we),
    .out_mask   (out_mask)
  );

endmodule

`default_nettype wire
